/* testbench/beam_patterns.txt */
// line a: weight_real weight_imag in_real in_imag in_last
// line b: expected out_real, out_imag, out_last
000000080 000000000 99AABBCC5566778811223344FAFE0208 0F1E2D3C4B5A69788796A5B4FF01807F 0
FFFF000000010002 00000000FFE00020 0
002000000 000000000 A5A5A5A5F9069C645A5A5A5A7F807F80 1234567803FB0500808080807F7F7F7F 1
FFFE0002FFE70019 0001FFFF00010000 1
400000180 C00010000 FD007FFB7F7F7F7F050080030201800A 02007FF780808080FA008007FE017FEC 0
000100000080FFF8 00030000FFC00005 0
201008040 000000000 FD01FFFFFD01FFFFFB03FD01FB03FD01 0000807F0000807F0200807F0200807F 1
FFFF000200000001 00010000FFC00040 1
000000000 000000040 090A0B0C05060708010203047F00FB05 F0E0D0C0B0A090807060504001FFFD03 0
0000000000010000 0010000000000001 0
201008040 000000000 FD01FFFFFD01FFFFFB03FD01FB03FD01 0000807F0000807F0200807F0200807F 0
FFFF000200000001 00010000FFC00040 0
400000180 C00010000 FD007FFB7F7F7F7F050080030201800A 02007FF780808080FA008007FE017FEC 1
000100000080FFF8 00030000FFC00005 1
000000080 000000000 99AABBCC5566778811223344FAFE0208 0F1E2D3C4B5A69788796A5B4FF01807F 1
FFFF000000010002 00000000FFE00020 1
000000000 000000040 090A0B0C05060708010203047F00FB05 F0E0D0C0B0A090807060504001FFFD03 1
0000000000010000 0010000000000001 1
002000000 000000000 A5A5A5A5F9069C645A5A5A5A7F807F80 1234567803FB0500808080807F7F7F7F 0
FFFE0002FFE70019 0001FFFF00010000 0
000000080 000000000 99AABBCC5566778811223344FAFE0208 0F1E2D3C4B5A69788796A5B4FF01807F 0
FFFF000000010002 00000000FFE00020 0
400000180 C00010000 FD007FFB7F7F7F7F050080030201800A 02007FF780808080FA008007FE017FEC 1
000100000080FFF8 00030000FFC00005 1

/* sim.f */
design/beam_pkg.sv
design/weight_multiplier.sv
design/beat_fifo.sv
design/channel_summer.sv
design/beam_combiner_top.sv
testbench/beam_combiner_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing
TOP = beam_combiner_tb
FILELIST = sim.f
OBJ_DIR = obj_dir
PASS_MSG = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/beam_combiner_tb.sv */
`timescale 1ns/1ps

module beam_combiner_tb;

    // every record is eight words: two weights, two input parts, last, expected beat
    localparam int record_count = 12;
    localparam int record_words = 8;
    // the first records go through one at a time so their latency can be measured
    localparam int idle_records = 5;
    localparam int cycle_limit = 16 + 30 * record_count;

    logic                                  clock;
    logic                                  resetn;
    logic                                  in_valid;
    logic                                  in_ready;
    logic [beam_pkg::in_part_width-1:0]    in_real;
    logic [beam_pkg::in_part_width-1:0]    in_imag;
    logic                                  in_last;
    logic [beam_pkg::weight_bus_width-1:0] weight_real;
    logic [beam_pkg::weight_bus_width-1:0] weight_imag;
    logic                                  out_valid;
    logic                                  out_ready;
    logic [beam_pkg::out_part_width-1:0]   out_real;
    logic [beam_pkg::out_part_width-1:0]   out_imag;
    logic                                  out_last;

    logic [127:0] patterns [record_count * record_words];
    time          xfer_time [record_count];
    integer       seed;
    int           errors;
    int           cycles;
    int           out_index;
    bit           input_stalled;

    beam_combiner_top i_dut (
        .clock       (clock),
        .resetn      (resetn),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_real     (in_real),
        .in_imag     (in_imag),
        .in_last     (in_last),
        .weight_real (weight_real),
        .weight_imag (weight_imag),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_real    (out_real),
        .out_imag    (out_imag),
        .out_last    (out_last)
    );

    task automatic check_word(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // the run is bounded by the number of records, with room for every stall
    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clock);
            cycles++;
        end
        errors++;
        $display("timeout after %0d cycles, only %0d of %0d output beats arrived",
                 cycles, out_index, record_count);
        $display("checks done: %0d errors", errors);
        $display("Finished with errors");
        $finish;
    end

    // reset, then the driver, which presents the records in order on falling edges
    initial begin
        int base;

        in_valid = 1'b0;
        in_real = '0;
        in_imag = '0;
        in_last = 1'b0;
        weight_real = '0;
        weight_imag = '0;
        out_ready = 1'b1;
        resetn = 1'b0;
        seed = 74920;
        errors = 0;
        out_index = 0;
        input_stalled = 1'b0;
        $readmemh("testbench/beam_patterns.txt", patterns);
        repeat (16) begin
            @(negedge clock);
            check_bit("out_valid", 1'b0, out_valid);
            check_bit("out_last", 1'b0, out_last);
            check_bit("in_ready", 1'b0, in_ready);
        end
        resetn = 1'b1;
        @(negedge clock);
        check_bit("in_ready", 1'b1, in_ready);
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("out_last", 1'b0, out_last);
        for (int i = 0; i < record_count; i++) begin
            base = i * record_words;
            weight_real = patterns[base][beam_pkg::weight_bus_width-1:0];
            weight_imag = patterns[base + 1][beam_pkg::weight_bus_width-1:0];
            in_real = patterns[base + 2];
            in_imag = patterns[base + 3];
            in_last = patterns[base + 4][0];
            in_valid = 1'b1;
            // out_ready changes on the same edge, so in_ready is looked at a little later
            #1;
            while (!in_ready) begin
                input_stalled = 1'b1;
                @(negedge clock);
                #1;
            end
            @(posedge clock);
            xfer_time[i] = $time;
            @(negedge clock);
            in_valid = 1'b0;
            // the latency records wait for an empty pipeline before the next one
            if (i < idle_records) begin
                wait (out_index > i);
                @(negedge clock);
            end
        end
        wait (out_index == record_count);
        repeat (4) @(negedge clock);
        if (!input_stalled) begin
            errors++;
            $display("in_ready never fell while the output was held back");
        end
        $display("checks done: %0d errors, %0d of %0d output beats", errors, out_index,
                 record_count);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // output is held low long enough to fill the FIFO, then released at random
    initial begin
        integer rnd;

        wait (out_index == idle_records);
        @(negedge clock);
        out_ready = 1'b0;
        repeat (12) @(negedge clock);
        forever begin
            rnd = $random(seed);
            out_ready = rnd[0];
            @(negedge clock);
        end
    end

    // each output transfer is matched against the next expected record
    initial begin
        int base;
        time lat;
        bit held;
        logic [63:0] held_real;
        logic [63:0] held_imag;
        logic held_last;

        held = 1'b0;
        forever begin
            @(negedge clock);
            #1;
            if (resetn && out_valid && out_index >= record_count) begin
                errors++;
                $display("an output beat arrived after all records were received");
            end else if (resetn && out_valid) begin
                // a beat that waited must not have moved
                if (held) begin
                    check_word("out_real while held", held_real, out_real);
                    check_word("out_imag while held", held_imag, out_imag);
                    check_bit("out_last while held", held_last, out_last);
                end
                if (out_ready) begin
                    base = out_index * record_words;
                    check_word("out_real", patterns[base + 5][63:0], out_real);
                    check_word("out_imag", patterns[base + 6][63:0], out_imag);
                    check_bit("out_last", patterns[base + 7][0], out_last);
                    if (out_index < idle_records) begin
                        // latency runs from the input transfer edge to the output
                        // transfer on the rising edge 4 ns from now
                        lat = ($time + 4 - xfer_time[out_index]) / 10;
                        if (lat != 3) begin
                            errors++;
                            $display("FAILED at %0t: latency expected 3, got %0d", $time, lat);
                        end
                    end
                    out_index++;
                    held = 1'b0;
                end else begin
                    held = 1'b1;
                    held_real = out_real;
                    held_imag = out_imag;
                    held_last = out_last;
                end
            end
        end
    end

endmodule

/* design/beam_combiner_top.sv */
`timescale 1ns/1ps

module beam_combiner_top (
    input  logic                                  clock,
    input  logic                                  resetn,
    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  logic [beam_pkg::in_part_width-1:0]    in_real,
    input  logic [beam_pkg::in_part_width-1:0]    in_imag,
    input  logic                                  in_last,
    input  logic [beam_pkg::weight_bus_width-1:0] weight_real,
    input  logic [beam_pkg::weight_bus_width-1:0] weight_imag,
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic [beam_pkg::out_part_width-1:0]   out_real,
    output logic [beam_pkg::out_part_width-1:0]   out_imag,
    output logic                                  out_last
);

    // weighted beats on their way into the FIFO
    logic                                     weighted_valid;
    logic                                     weighted_ready;
    logic [beam_pkg::weighted_part_width-1:0] weighted_real;
    logic [beam_pkg::weighted_part_width-1:0] weighted_imag;
    logic                                     weighted_last;

    // oldest buffered beat offered to the summer
    logic                                     queued_valid;
    logic                                     queued_ready;
    logic [beam_pkg::weighted_part_width-1:0] queued_real;
    logic [beam_pkg::weighted_part_width-1:0] queued_imag;
    logic                                     queued_last;

    weight_multiplier i_weight_multiplier (
        .clock          (clock),
        .resetn         (resetn),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_real        (in_real),
        .in_imag        (in_imag),
        .in_last        (in_last),
        .weight_real    (weight_real),
        .weight_imag    (weight_imag),
        .weighted_valid (weighted_valid),
        .weighted_ready (weighted_ready),
        .weighted_real  (weighted_real),
        .weighted_imag  (weighted_imag),
        .weighted_last  (weighted_last)
    );

    beat_fifo i_beat_fifo (
        .clock          (clock),
        .resetn         (resetn),
        .weighted_valid (weighted_valid),
        .weighted_ready (weighted_ready),
        .weighted_real  (weighted_real),
        .weighted_imag  (weighted_imag),
        .weighted_last  (weighted_last),
        .queued_valid   (queued_valid),
        .queued_ready   (queued_ready),
        .queued_real    (queued_real),
        .queued_imag    (queued_imag),
        .queued_last    (queued_last)
    );

    channel_summer i_channel_summer (
        .clock        (clock),
        .resetn       (resetn),
        .queued_valid (queued_valid),
        .queued_ready (queued_ready),
        .queued_real  (queued_real),
        .queued_imag  (queued_imag),
        .queued_last  (queued_last),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_real     (out_real),
        .out_imag     (out_imag),
        .out_last     (out_last)
    );

endmodule

/* design/channel_summer.sv */
`timescale 1ns/1ps

module channel_summer (
    input  logic                                     clock,
    input  logic                                     resetn,
    input  logic                                     queued_valid,
    output logic                                     queued_ready,
    input  logic [beam_pkg::weighted_part_width-1:0] queued_real,
    input  logic [beam_pkg::weighted_part_width-1:0] queued_imag,
    input  logic                                     queued_last,
    output logic                                     out_valid,
    input  logic                                     out_ready,
    output logic [beam_pkg::out_part_width-1:0]      out_real,
    output logic [beam_pkg::out_part_width-1:0]      out_imag,
    output logic                                     out_last
);

    logic                                queued_transfer;
    logic [beam_pkg::out_part_width-1:0] next_real;
    logic [beam_pkg::out_part_width-1:0] next_imag;

    // a held output beat blocks the FIFO until the outside takes it
    assign queued_ready = !out_valid || out_ready;
    assign queued_transfer = queued_valid && queued_ready;

    // per slot, add the four channels and divide by four with half up rounding
    always_comb begin
        int in_base;
        logic signed [beam_pkg::sum_width-1:0] acc_real;
        logic signed [beam_pkg::sum_width-1:0] acc_imag;
        logic signed [beam_pkg::sum_width-1:0] round_real;
        logic signed [beam_pkg::sum_width-1:0] round_imag;

        next_real = '0;
        next_imag = '0;
        for (int s = 0; s < beam_pkg::samples_per_beat; s++) begin
            acc_real = '0;
            acc_imag = '0;
            for (int c = 0; c < beam_pkg::num_channels; c++) begin
                in_base = (c * beam_pkg::samples_per_beat + s) * beam_pkg::weighted_width;
                acc_real = acc_real + {{beam_pkg::weighted_pad{
                    queued_real[in_base + beam_pkg::weighted_width - 1]}},
                    queued_real[in_base +: beam_pkg::weighted_width]};
                acc_imag = acc_imag + {{beam_pkg::weighted_pad{
                    queued_imag[in_base + beam_pkg::weighted_width - 1]}},
                    queued_imag[in_base +: beam_pkg::weighted_width]};
            end
            round_real = (acc_real + beam_pkg::sum_round) >>> beam_pkg::sum_shift;
            round_imag = (acc_imag + beam_pkg::sum_round) >>> beam_pkg::sum_shift;
            next_real[s * beam_pkg::out_sample_width +: beam_pkg::out_sample_width] =
                round_real[beam_pkg::out_sample_width-1:0];
            next_imag[s * beam_pkg::out_sample_width +: beam_pkg::out_sample_width] =
                round_imag[beam_pkg::out_sample_width-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_valid <= 1'b0;
            out_last <= 1'b0;
        end else if (queued_transfer) begin
            out_valid <= 1'b1;
            out_last <= queued_last;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // the sums stay put while out_ready is low
    always_ff @(posedge clock) begin
        if (queued_transfer) begin
            out_real <= next_real;
            out_imag <= next_imag;
        end
    end

endmodule

/* design/beat_fifo.sv */
`timescale 1ns/1ps

module beat_fifo (
    input  logic                                     clock,
    input  logic                                     resetn,
    input  logic                                     weighted_valid,
    output logic                                     weighted_ready,
    input  logic [beam_pkg::weighted_part_width-1:0] weighted_real,
    input  logic [beam_pkg::weighted_part_width-1:0] weighted_imag,
    input  logic                                     weighted_last,
    output logic                                     queued_valid,
    input  logic                                     queued_ready,
    output logic [beam_pkg::weighted_part_width-1:0] queued_real,
    output logic [beam_pkg::weighted_part_width-1:0] queued_imag,
    output logic                                     queued_last
);

    logic [beam_pkg::weighted_part_width-1:0] real_mem [beam_pkg::fifo_depth];
    logic [beam_pkg::weighted_part_width-1:0] imag_mem [beam_pkg::fifo_depth];
    logic                                     last_mem [beam_pkg::fifo_depth];
    logic [beam_pkg::fifo_addr_width-1:0]     wr_ptr;
    logic [beam_pkg::fifo_addr_width-1:0]     rd_ptr;
    logic [beam_pkg::fifo_addr_width:0]       count;
    logic                                     full;
    logic                                     push;
    logic                                     pop;

    // depth is a power of two, so the count only reaches its top bit when full
    assign full = count[beam_pkg::fifo_addr_width];
    assign queued_valid = (count != '0);
    assign pop = queued_valid && queued_ready;

    // a full FIFO still takes a beat when the oldest one leaves in the same cycle
    assign weighted_ready = !full || pop;
    assign push = weighted_valid && weighted_ready;

    // oldest entry comes straight out of the storage registers
    assign queued_real = real_mem[rd_ptr];
    assign queued_imag = imag_mem[rd_ptr];
    assign queued_last = last_mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            real_mem[wr_ptr] <= weighted_real;
            imag_mem[wr_ptr] <= weighted_imag;
            last_mem[wr_ptr] <= weighted_last;
        end
    end

    // pointers wrap on their own since the depth fills the address range
    always_ff @(posedge clock) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/weight_multiplier.sv */
`timescale 1ns/1ps

module weight_multiplier (
    input  logic                                     clock,
    input  logic                                     resetn,
    input  logic                                     in_valid,
    output logic                                     in_ready,
    input  logic [beam_pkg::in_part_width-1:0]       in_real,
    input  logic [beam_pkg::in_part_width-1:0]       in_imag,
    input  logic                                     in_last,
    input  logic [beam_pkg::weight_bus_width-1:0]    weight_real,
    input  logic [beam_pkg::weight_bus_width-1:0]    weight_imag,
    output logic                                     weighted_valid,
    input  logic                                     weighted_ready,
    output logic [beam_pkg::weighted_part_width-1:0] weighted_real,
    output logic [beam_pkg::weighted_part_width-1:0] weighted_imag,
    output logic                                     weighted_last
);

    logic                                     started;
    logic                                     in_transfer;
    logic [beam_pkg::weighted_part_width-1:0] next_real;
    logic [beam_pkg::weighted_part_width-1:0] next_imag;

    // the register takes a new beat when it is empty or drains in the same cycle,
    // and the input stays closed until the first cycle after reset
    assign in_ready = started && (!weighted_valid || weighted_ready);
    assign in_transfer = in_valid && in_ready;

    // complex product of every sample with its channel weight, rounded back to
    // sample scale by dropping the seven fractional bits of the weight
    always_comb begin
        int in_base;
        int out_base;
        logic signed [beam_pkg::product_width-1:0] wr;
        logic signed [beam_pkg::product_width-1:0] wi;
        logic signed [beam_pkg::product_width-1:0] xr;
        logic signed [beam_pkg::product_width-1:0] xi;
        logic signed [beam_pkg::product_width-1:0] prod_real;
        logic signed [beam_pkg::product_width-1:0] prod_imag;
        logic signed [beam_pkg::product_width-1:0] round_real;
        logic signed [beam_pkg::product_width-1:0] round_imag;

        next_real = '0;
        next_imag = '0;
        for (int c = 0; c < beam_pkg::num_channels; c++) begin
            wr = {{beam_pkg::weight_pad{weight_real[(c + 1) * beam_pkg::weight_width - 1]}},
                  weight_real[c * beam_pkg::weight_width +: beam_pkg::weight_width]};
            wi = {{beam_pkg::weight_pad{weight_imag[(c + 1) * beam_pkg::weight_width - 1]}},
                  weight_imag[c * beam_pkg::weight_width +: beam_pkg::weight_width]};
            for (int s = 0; s < beam_pkg::samples_per_beat; s++) begin
                in_base = (c * beam_pkg::samples_per_beat + s) * beam_pkg::sample_width;
                out_base = (c * beam_pkg::samples_per_beat + s) * beam_pkg::weighted_width;
                xr = {{beam_pkg::sample_pad{in_real[in_base + beam_pkg::sample_width - 1]}},
                      in_real[in_base +: beam_pkg::sample_width]};
                xi = {{beam_pkg::sample_pad{in_imag[in_base + beam_pkg::sample_width - 1]}},
                      in_imag[in_base +: beam_pkg::sample_width]};
                // (wr + j*wi)(xr + j*xi), the real part takes the minus sign
                prod_real = wr * xr - wi * xi;
                prod_imag = wr * xi + wi * xr;
                round_real = (prod_real + beam_pkg::mult_round) >>> beam_pkg::weight_frac_bits;
                round_imag = (prod_imag + beam_pkg::mult_round) >>> beam_pkg::weight_frac_bits;
                // the rounded value fits in 11 bits so the low 16 bits are its sign extension
                next_real[out_base +: beam_pkg::weighted_width] =
                    round_real[beam_pkg::weighted_width-1:0];
                next_imag[out_base +: beam_pkg::weighted_width] =
                    round_imag[beam_pkg::weighted_width-1:0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            started <= 1'b0;
            weighted_valid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (in_transfer) begin
                weighted_valid <= 1'b1;
            end else if (weighted_ready) begin
                weighted_valid <= 1'b0;
            end
        end
    end

    // payload only moves on an accepted beat and is otherwise held for the FIFO
    always_ff @(posedge clock) begin
        if (in_transfer) begin
            weighted_real <= next_real;
            weighted_imag <= next_imag;
            weighted_last <= in_last;
        end
    end

endmodule

/* design/beam_pkg.sv */
package beam_pkg;

    // array geometry: four antenna channels, four sample slots in every beat
    localparam int num_channels = 4;
    localparam int samples_per_beat = 4;

    // signed input sample and Q1.7 weight, so 1.0 is 128 and -1.0 is -128
    localparam int sample_width = 8;
    localparam int weight_width = 9;
    localparam int weight_frac_bits = 7;

    // one complex multiply needs 17 bits, and the sum of two products needs 18
    localparam int product_width = 18;
    localparam int weighted_width = 16;

    // four weighted samples summed need 18 bits before the divide by four
    localparam int sum_width = 18;
    localparam int sum_shift = 2;
    localparam int out_sample_width = 16;

    // sign extension widths used to widen operands before the arithmetic
    localparam int sample_pad = product_width - sample_width;
    localparam int weight_pad = product_width - weight_width;
    localparam int weighted_pad = sum_width - weighted_width;

    // half an LSB at each rounding point, which gives round half up
    localparam logic signed [product_width-1:0] mult_round =
        {{(product_width - weight_frac_bits){1'b0}}, 1'b1, {(weight_frac_bits - 1){1'b0}}};
    localparam logic signed [sum_width-1:0] sum_round =
        {{(sum_width - sum_shift){1'b0}}, 1'b1, {(sum_shift - 1){1'b0}}};

    // bus widths, with channel as the outer index and slot as the inner one
    localparam int in_part_width = num_channels * samples_per_beat * sample_width;
    localparam int weighted_part_width = num_channels * samples_per_beat * weighted_width;
    localparam int out_part_width = samples_per_beat * out_sample_width;
    localparam int weight_bus_width = num_channels * weight_width;

    // the beat FIFO between the multiplier and the summer
    localparam int fifo_depth = 4;
    localparam int fifo_addr_width = 2;

endpackage
